//--- verilog/ring_pkg.sv
/* Ring packet field types, the packet type encoding and the L1 data
   cache geometry shared by every stage of the ring node */

package ring_pkg;

	// Cache geometry: four sets of two ways each
	localparam int num_sets = 4;
	localparam int num_ways = 2;

	// Index widths follow from the geometry
	localparam int set_idx_bits = $clog2(num_sets);
	localparam int way_idx_bits = $clog2(num_ways);

	// A line address counts whole cache lines, so there is no byte offset
	typedef logic [31:0] line_addr_t;

	// One full cache line travels in a single ring packet
	typedef logic [63:0] line_data_t;

	// Node number on the ring
	typedef logic [1:0] core_id_t;

	// The low address bits select the set
	typedef logic [set_idx_bits - 1:0] set_idx_t;

	// Way within a set
	typedef logic [way_idx_bits - 1:0] way_idx_t;

	// Everything above the set index is the tag
	typedef logic [$bits(line_addr_t) - set_idx_bits - 1:0] cache_tag_t;

	// Kinds of packet on the ring
	// An empty slot carries all zero fields, which reads as a request type
	typedef enum logic [1:0]
	{
		PKT_READ_REQ = 2'd0,
		PKT_L2_RESPONSE = 2'd1,
		PKT_L2_WRITEBACK = 2'd2
	} packet_type_t;

endpackage

//--- verilog/l1_data_array.sv
/* L1 data line storage, two ways per set, registered read with
   write-first forwarding */
`timescale 1ns/100ps

module l1_data_array
	(input logic clk,

	// Read port, data valid the cycle after the address
	input ring_pkg::set_idx_t read_set,
	input ring_pkg::way_idx_t read_way,
	output ring_pkg::line_data_t read_data,

	// Write port
	input logic update_en,
	input ring_pkg::way_idx_t update_way,
	input ring_pkg::set_idx_t update_set,
	input ring_pkg::line_data_t update_data);

	ring_pkg::line_data_t lines[ring_pkg::num_sets][ring_pkg::num_ways];
	logic write_collides;

	// Read and write address the same line in this cycle
	assign write_collides = update_en && update_set == read_set && update_way == read_way;

	always_ff @(posedge clk)
	begin
		if (update_en)
			lines[update_set][update_way] <= update_data;

		// The new data wins over the stored copy on a collision
		if (write_collides)
			read_data <= update_data;
		else
			read_data <= lines[read_set][read_way];
	end

endmodule

//--- verilog/ring_tag_stage.sv
/* Ring stage 1: response decode for this core, tag and valid storage,
   round robin replacement and victim selection */
`timescale 1ns/100ps

module ring_tag_stage
	#(parameter ring_pkg::core_id_t core_id = 0)
	(input logic clk,
	input logic reset,

	// Packet arriving from the previous node
	input logic ring_in_valid,
	input logic ring_in_ack,
	input ring_pkg::packet_type_t ring_in_packet_type,
	input ring_pkg::core_id_t ring_in_dest_core,
	input ring_pkg::line_addr_t ring_in_address,
	input ring_pkg::line_data_t ring_in_data,

	// Packet toward stage 2
	output logic rc1_valid,
	output logic rc1_ack,
	output ring_pkg::packet_type_t rc1_packet_type,
	output ring_pkg::core_id_t rc1_dest_core,
	output ring_pkg::line_addr_t rc1_address,
	output ring_pkg::line_data_t rc1_data,

	// Fill decision that travels along with the packet
	output logic rc1_fill_en,
	output ring_pkg::way_idx_t rc1_fill_way,
	output logic rc1_need_writeback,
	output ring_pkg::line_addr_t rc1_evicted_addr);

	ring_pkg::cache_tag_t tags[ring_pkg::num_sets][ring_pkg::num_ways];
	logic [ring_pkg::num_ways - 1:0] valid_bits[ring_pkg::num_sets];
	logic [ring_pkg::num_sets - 1:0] replace_bits;
	logic response_for_me;
	ring_pkg::set_idx_t in_set;
	ring_pkg::cache_tag_t in_tag;
	ring_pkg::way_idx_t victim_way;

	// The only place where a response for this core is recognized
	assign response_for_me = ring_in_valid && ring_in_ack && ring_in_dest_core == core_id
		&& ring_in_packet_type == ring_pkg::PKT_L2_RESPONSE;

	// Split the incoming line address into set and tag
	assign in_set = ring_in_address[ring_pkg::set_idx_bits - 1:0];
	assign in_tag = ring_in_address[$bits(ring_pkg::line_addr_t) - 1:ring_pkg::set_idx_bits];

	// The replacement bit of the set names the way that gets the fill
	assign victim_way = ring_pkg::way_idx_t'(replace_bits[in_set]);

	// Control state: valid bits, replacement bits and the fill flags
	// Updated on the same edge that registers rc1, so the next packet sees it
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int set = 0; set < ring_pkg::num_sets; set++)
				valid_bits[set] <= '0;

			replace_bits <= '0;
			rc1_valid <= 1'b0;
			rc1_fill_en <= 1'b0;
			rc1_need_writeback <= 1'b0;
		end
		else
		begin
			rc1_valid <= ring_in_valid;
			rc1_fill_en <= response_for_me;

			// A valid victim always goes back out, since dirty state is not kept
			rc1_need_writeback <= response_for_me && valid_bits[in_set][victim_way];
			if (response_for_me)
			begin
				valid_bits[in_set][victim_way] <= 1'b1;
				replace_bits[in_set] <= !replace_bits[in_set];
			end
		end
	end

	// Tag storage and packet payload
	always_ff @(posedge clk)
	begin
		if (response_for_me)
			tags[in_set][victim_way] <= in_tag;

		rc1_ack <= ring_in_ack;
		rc1_packet_type <= ring_in_packet_type;
		rc1_dest_core <= ring_in_dest_core;
		rc1_address <= ring_in_address;
		rc1_data <= ring_in_data;
		rc1_fill_way <= victim_way;

		// Old tag joined with the set gives the line address of the victim
		rc1_evicted_addr <= {tags[in_set][victim_way], in_set};
	end

endmodule

//--- verilog/ring_read_stage.sv
/* Ring stage 2: packet register and victim line read request */
`timescale 1ns/100ps

module ring_read_stage
	(input logic clk,
	input logic reset,

	// Packet and fill decision from stage 1
	input logic rc1_valid,
	input logic rc1_ack,
	input ring_pkg::packet_type_t rc1_packet_type,
	input ring_pkg::core_id_t rc1_dest_core,
	input ring_pkg::line_addr_t rc1_address,
	input ring_pkg::line_data_t rc1_data,
	input logic rc1_fill_en,
	input ring_pkg::way_idx_t rc1_fill_way,
	input logic rc1_need_writeback,
	input ring_pkg::line_addr_t rc1_evicted_addr,

	// Same information one cycle later, toward stage 3
	output logic rc2_valid,
	output logic rc2_ack,
	output ring_pkg::packet_type_t rc2_packet_type,
	output ring_pkg::core_id_t rc2_dest_core,
	output ring_pkg::line_addr_t rc2_address,
	output ring_pkg::line_data_t rc2_data,
	output logic rc2_fill_en,
	output ring_pkg::way_idx_t rc2_fill_way,
	output logic rc2_need_writeback,
	output ring_pkg::line_addr_t rc2_evicted_addr,

	// Victim read address to the data array
	output ring_pkg::set_idx_t read_set,
	output ring_pkg::way_idx_t read_way);

	// The old line is read now so it is ready when stage 3 builds the writeback
	// The read is issued for every packet and only used when a writeback is due
	assign read_set = rc1_address[ring_pkg::set_idx_bits - 1:0];
	assign read_way = rc1_fill_way;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rc2_valid <= 1'b0;
			rc2_fill_en <= 1'b0;
			rc2_need_writeback <= 1'b0;
		end
		else
		begin
			rc2_valid <= rc1_valid;
			rc2_fill_en <= rc1_fill_en;
			rc2_need_writeback <= rc1_need_writeback;
		end
	end

	// Payload fields move along without reset
	always_ff @(posedge clk)
	begin
		rc2_ack <= rc1_ack;
		rc2_packet_type <= rc1_packet_type;
		rc2_dest_core <= rc1_dest_core;
		rc2_address <= rc1_address;
		rc2_data <= rc1_data;
		rc2_fill_way <= rc1_fill_way;
		rc2_evicted_addr <= rc1_evicted_addr;
	end

endmodule

//--- verilog/ring_update_stage.sv
/* Ring stage 3: fill write into the data array and selection of the
   outgoing packet (forward, empty slot or writeback) */
`timescale 1ns/100ps

module ring_update_stage
	(input logic clk,
	input logic reset,

	// Packet and fill decision from stage 2
	input logic rc2_valid,
	input logic rc2_ack,
	input ring_pkg::packet_type_t rc2_packet_type,
	input ring_pkg::core_id_t rc2_dest_core,
	input ring_pkg::line_addr_t rc2_address,
	input ring_pkg::line_data_t rc2_data,
	input logic rc2_fill_en,
	input ring_pkg::way_idx_t rc2_fill_way,
	input logic rc2_need_writeback,
	input ring_pkg::line_addr_t rc2_evicted_addr,

	// Old line contents read during stage 2
	input ring_pkg::line_data_t read_data,

	// Write port of the data array
	output logic update_en,
	output ring_pkg::way_idx_t update_way,
	output ring_pkg::set_idx_t update_set,
	output ring_pkg::line_data_t update_data,

	// Packet to the next node
	output logic ring_out_valid,
	output logic ring_out_ack,
	output ring_pkg::packet_type_t ring_out_packet_type,
	output ring_pkg::core_id_t ring_out_dest_core,
	output ring_pkg::line_addr_t ring_out_address,
	output ring_pkg::line_data_t ring_out_data);

	logic out_valid_nxt;
	logic out_ack_nxt;
	ring_pkg::packet_type_t out_packet_type_nxt;
	ring_pkg::core_id_t out_dest_core_nxt;
	ring_pkg::line_addr_t out_address_nxt;
	ring_pkg::line_data_t out_data_nxt;

	// The fill is written at the end of this cycle, after stage 2 has
	// already captured the victim contents
	assign update_en = rc2_fill_en;
	assign update_way = rc2_fill_way;
	assign update_set = rc2_address[ring_pkg::set_idx_bits - 1:0];
	assign update_data = rc2_data;

	always_comb
	begin
		if (rc2_need_writeback)
		begin
			// The evicted line takes the slot of the consumed response
			out_valid_nxt = 1'b1;
			out_ack_nxt = 1'b0;
			out_packet_type_nxt = ring_pkg::PKT_L2_WRITEBACK;
			out_dest_core_nxt = '0;
			out_address_nxt = rc2_evicted_addr;
			out_data_nxt = read_data;
		end
		else if (rc2_fill_en)
		begin
			// Response consumed with nothing to push out
			// Leave an empty slot so other nodes get a turn
			out_valid_nxt = 1'b0;
			out_ack_nxt = 1'b0;
			out_packet_type_nxt = ring_pkg::PKT_READ_REQ;
			out_dest_core_nxt = '0;
			out_address_nxt = '0;
			out_data_nxt = '0;
		end
		else
		begin
			// Not ours, pass it on untouched
			out_valid_nxt = rc2_valid;
			out_ack_nxt = rc2_ack;
			out_packet_type_nxt = rc2_packet_type;
			out_dest_core_nxt = rc2_dest_core;
			out_address_nxt = rc2_address;
			out_data_nxt = rc2_data;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ring_out_valid <= 1'b0;
			ring_out_ack <= 1'b0;
			ring_out_packet_type <= ring_pkg::PKT_READ_REQ;
			ring_out_dest_core <= '0;
			ring_out_address <= '0;
			ring_out_data <= '0;
		end
		else
		begin
			ring_out_valid <= out_valid_nxt;
			ring_out_ack <= out_ack_nxt;
			ring_out_packet_type <= out_packet_type_nxt;
			ring_out_dest_core <= out_dest_core_nxt;
			ring_out_address <= out_address_nxt;
			ring_out_data <= out_data_nxt;
		end
	end

endmodule

//--- verilog/ring_node.sv
/* Ring node top: three stage fill pipeline around the L1 data array */
`timescale 1ns/100ps

module ring_node
	#(parameter ring_pkg::core_id_t core_id = 0)
	(input logic clk,
	input logic reset,

	// From the previous node
	input logic ring_in_valid,
	input logic ring_in_ack,
	input ring_pkg::packet_type_t ring_in_packet_type,
	input ring_pkg::core_id_t ring_in_dest_core,
	input ring_pkg::line_addr_t ring_in_address,
	input ring_pkg::line_data_t ring_in_data,

	// To the next node, three cycles later
	output logic ring_out_valid,
	output logic ring_out_ack,
	output ring_pkg::packet_type_t ring_out_packet_type,
	output ring_pkg::core_id_t ring_out_dest_core,
	output ring_pkg::line_addr_t ring_out_address,
	output ring_pkg::line_data_t ring_out_data);

	logic rc1_valid;
	logic rc1_ack;
	ring_pkg::packet_type_t rc1_packet_type;
	ring_pkg::core_id_t rc1_dest_core;
	ring_pkg::line_addr_t rc1_address;
	ring_pkg::line_data_t rc1_data;
	logic rc1_fill_en;
	ring_pkg::way_idx_t rc1_fill_way;
	logic rc1_need_writeback;
	ring_pkg::line_addr_t rc1_evicted_addr;
	logic rc2_valid;
	logic rc2_ack;
	ring_pkg::packet_type_t rc2_packet_type;
	ring_pkg::core_id_t rc2_dest_core;
	ring_pkg::line_addr_t rc2_address;
	ring_pkg::line_data_t rc2_data;
	logic rc2_fill_en;
	ring_pkg::way_idx_t rc2_fill_way;
	logic rc2_need_writeback;
	ring_pkg::line_addr_t rc2_evicted_addr;
	ring_pkg::set_idx_t read_set;
	ring_pkg::way_idx_t read_way;
	ring_pkg::line_data_t read_data;
	logic update_en;
	ring_pkg::way_idx_t update_way;
	ring_pkg::set_idx_t update_set;
	ring_pkg::line_data_t update_data;

	// Stage 1 decides on the fill and keeps the tags
	ring_tag_stage #(.core_id(core_id)) u_tag_stage(.*);

	// Stage 2 holds the packet while the victim line is read
	ring_read_stage u_read_stage(.*);

	l1_data_array u_data_array(.*);

	// Stage 3 writes the fill and drives the ring
	ring_update_stage u_update_stage(.*);

endmodule

//--- bench/ring_node_chk.sv
/* Bound assertions on the ring output and the data array write port */
`timescale 1ns/100ps

module ring_node_chk
	(input logic clk,
	input logic reset,
	input logic ring_in_valid,
	input logic ring_in_ack,
	input ring_pkg::packet_type_t ring_in_packet_type,
	input logic ring_out_valid,
	input logic ring_out_ack,
	input ring_pkg::packet_type_t ring_out_packet_type,
	input logic update_en);

	logic response_seen;

	// Failure counts that the testbench adds to its own error total
	int reset_failures = 0;
	int fill_failures = 0;
	int writeback_failures = 0;

	// Any acknowledged response entering the node for any destination
	assign response_seen = ring_in_valid && ring_in_ack
		&& ring_in_packet_type == ring_pkg::PKT_L2_RESPONSE;

	// The output register is held clear for the whole reset
	a_no_valid_in_reset: assert property (@(posedge clk) reset |-> !ring_out_valid)
	else
	begin
		reset_failures++;
		$error("ring_out_valid high during reset");
	end

	// A fill write reaches the array two edges after the response came in
	a_fill_follows_response: assert property (@(posedge clk) disable iff (reset)
		update_en |-> $past(response_seen, 2))
	else
	begin
		fill_failures++;
		$error("update_en without a response two cycles earlier");
	end

	// Writebacks are new requests toward L2 and never carry an ack
	a_writeback_no_ack: assert property (@(posedge clk) disable iff (reset)
		ring_out_valid && ring_out_packet_type == ring_pkg::PKT_L2_WRITEBACK
		|-> !ring_out_ack)
	else
	begin
		writeback_failures++;
		$error("writeback packet leaves the node with ack set");
	end

endmodule

bind ring_node ring_node_chk u_ring_node_chk(.*);

//--- bench/ring_node_tb.sv
/* Ring node testbench with clock and reset, LFSR stimulus, reference cache
   model, compare process and result report */
`timescale 1ns/100ps

module ring_node_tb
	#(parameter ring_pkg::core_id_t node_id = 2'd1);

	// Packed packet with valid, ack, type, dest, address and data from the top down
	typedef logic [101:0] ring_packet_t;

	logic clk;
	logic reset;
	logic ring_in_valid;
	logic ring_in_ack;
	ring_pkg::packet_type_t ring_in_packet_type;
	ring_pkg::core_id_t ring_in_dest_core;
	ring_pkg::line_addr_t ring_in_address;
	ring_pkg::line_data_t ring_in_data;
	logic ring_out_valid;
	logic ring_out_ack;
	ring_pkg::packet_type_t ring_out_packet_type;
	ring_pkg::core_id_t ring_out_dest_core;
	ring_pkg::line_addr_t ring_out_address;
	ring_pkg::line_data_t ring_out_data;
	ring_packet_t expected_q[$];
	logic [31:0] lfsr_state;
	int sent_count = 0;
	int checks_done = 0;
	int error_count = 0;
	int test_checks = 0;
	int test_errors = 0;

	// Reference cache state that is kept in packet order
	ring_pkg::cache_tag_t model_tags[ring_pkg::num_sets][ring_pkg::num_ways];
	ring_pkg::line_data_t model_lines[ring_pkg::num_sets][ring_pkg::num_ways];
	logic model_valid[ring_pkg::num_sets][ring_pkg::num_ways];
	logic model_repl[ring_pkg::num_sets];

	ring_node #(.core_id(node_id)) u_ring_node(.*);

	always #5 clk = ~clk;

	// Galois LFSR stepped once for every bit handed out, with the first bit lowest
	function automatic logic [63:0] random_bits(input int count);
		logic [63:0] bits;
		logic lsb;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lsb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb)
				lfsr_state = lfsr_state ^ 32'h8020_0003;
			bits[i] = lsb;
		end
		return bits;
	endfunction

	// Expected ring output for one input packet while the cache state is updated
	function automatic ring_packet_t model_packet(input logic valid, input logic ack,
		input ring_pkg::packet_type_t ptype, input ring_pkg::core_id_t dest,
		input ring_pkg::line_addr_t addr, input ring_pkg::line_data_t data);
		ring_pkg::set_idx_t set_sel;
		ring_pkg::way_idx_t way_sel;
		ring_packet_t result;
		set_sel = addr[1:0];
		way_sel = model_repl[set_sel];
		if (valid && ack && dest == node_id && ptype == ring_pkg::PKT_L2_RESPONSE)
		begin
			// An occupied victim goes out as a writeback and a free way empties the slot
			if (model_valid[set_sel][way_sel])
				result = {1'b1, 1'b0, ring_pkg::PKT_L2_WRITEBACK, 2'd0,
					model_tags[set_sel][way_sel], set_sel, model_lines[set_sel][way_sel]};
			else
				result = '0;
			model_tags[set_sel][way_sel] = addr[31:2];
			model_lines[set_sel][way_sel] = data;
			model_valid[set_sel][way_sel] = 1'b1;
			model_repl[set_sel] = !model_repl[set_sel];
		end
		else
			result = {valid, ack, ptype, dest, addr, data};
		return result;
	endfunction

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("Fail at time %0t: %s is %h, expected %h", $time, name, actual, expected);
			error_count++;
		end
	endtask

	task automatic compare_packet(input ring_packet_t exp);
		check_value("ring_out_valid", 64'(ring_out_valid), 64'(exp[101]));
		check_value("ring_out_ack", 64'(ring_out_ack), 64'(exp[100]));
		check_value("ring_out_packet_type", 64'(ring_out_packet_type), 64'(exp[99:98]));
		check_value("ring_out_dest_core", 64'(ring_out_dest_core), 64'(exp[97:96]));
		check_value("ring_out_address", 64'(ring_out_address), 64'(exp[95:64]));
		check_value("ring_out_data", ring_out_data, exp[63:0]);
	endtask

	// Put one slot on the ring input
	task automatic drive_ring_in(input logic valid, input logic ack,
		input ring_pkg::packet_type_t ptype, input ring_pkg::core_id_t dest,
		input ring_pkg::line_addr_t addr, input ring_pkg::line_data_t data);
		ring_in_valid = valid;
		ring_in_ack = ack;
		ring_in_packet_type = ptype;
		ring_in_dest_core = dest;
		ring_in_address = addr;
		ring_in_data = data;
	endtask

	// Drive one slot on the falling edge and queue what must come out
	task automatic send_packet(input logic valid, input logic ack,
		input ring_pkg::packet_type_t ptype, input ring_pkg::core_id_t dest,
		input ring_pkg::line_addr_t addr, input ring_pkg::line_data_t data);
		@(negedge clk);
		drive_ring_in(valid, ack, ptype, dest, addr, data);
		expected_q.push_back(model_packet(valid, ack, ptype, dest, addr, data));
		sent_count++;
	endtask

	task automatic send_idle();
		send_packet(1'b0, 1'b0, ring_pkg::PKT_READ_REQ, 2'd0, 32'd0, 64'd0);
	endtask

	task automatic send_fill(input ring_pkg::line_addr_t addr, input ring_pkg::line_data_t data);
		send_packet(1'b1, 1'b1, ring_pkg::PKT_L2_RESPONSE, node_id, addr, data);
	endtask

	task automatic send_random_packet(input logic allow_fill);
		logic valid;
		logic ack;
		logic [1:0] type_bits;
		ring_pkg::packet_type_t ptype;
		ring_pkg::core_id_t dest;
		ring_pkg::line_addr_t addr;
		ring_pkg::line_data_t data;
		valid = 1'(random_bits(1));
		ack = 1'(random_bits(1));
		type_bits = 2'(random_bits(2));
		case (type_bits)
			2'd1: ptype = ring_pkg::PKT_L2_RESPONSE;
			2'd2: ptype = ring_pkg::PKT_L2_WRITEBACK;
			default: ptype = ring_pkg::PKT_READ_REQ;
		endcase
		dest = 2'(random_bits(2));
		addr = 32'(random_bits(32));
		data = random_bits(64);

		// Writebacks from other nodes are never acknowledged on a sane ring
		if (ptype == ring_pkg::PKT_L2_WRITEBACK)
			ack = 1'b0;

		// Steer a response for this node to a neighbour when fills are unwanted
		if (!allow_fill && valid && ack && dest == node_id && ptype == ring_pkg::PKT_L2_RESPONSE)
			dest = node_id + 2'd1;
		send_packet(valid, ack, ptype, dest, addr, data);
	endtask

	// Keep the ring busy with idle slots until every queued packet is checked
	task automatic finish_test(input string name);
		int target;
		int waited;
		target = sent_count;
		waited = 0;
		while (checks_done < target && waited < 20)
		begin
			send_idle();
			waited++;
		end
		if (checks_done < target)
		begin
			$display("Timeout: test %s never saw all its packets on ring_out", name);
			$display("sim failed");
			$finish;
		end
		else
		begin
			$display("Test %s done: %0d packets checked, %0d errors", name,
				checks_done - test_checks, error_count - test_errors);
			test_checks = checks_done;
			test_errors = error_count;
		end
	endtask

	// A slot driven at one falling edge passes three register stages and is
	// checked just after the third falling edge that follows
	initial
	begin
		ring_packet_t expected;
		forever
		begin
			@(negedge clk);
			#1;
			if (expected_q.size() > 3)
			begin
				expected = expected_q.pop_front();
				compare_packet(expected);
				checks_done++;
			end
		end
	end

	initial
	begin
		logic [1:0] choose;
		clk = 1'b0;
		reset = 1'b1;

		// An acknowledged response for this node sits on ring_in during reset
		drive_ring_in(1'b1, 1'b1, ring_pkg::PKT_L2_RESPONSE, node_id, 32'h0000_5002,
			64'h0123_4567_89ab_cdef);
		lfsr_state = 32'hbe0c_ecee;
		for (int set = 0; set < ring_pkg::num_sets; set++)
		begin
			model_repl[set] = 1'b0;
			for (int way = 0; way < ring_pkg::num_ways; way++)
				model_valid[set][way] = 1'b0;
		end
		repeat (12) @(negedge clk);

		// The pipeline is full of that packet but reset keeps ring_out clear
		compare_packet('0);
		drive_ring_in(1'b0, 1'b0, ring_pkg::PKT_READ_REQ, 2'd0, 32'd0, 64'd0);
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// Reset leaves every output field at zero before any traffic
		compare_packet('0);
		repeat (4) send_idle();
		finish_test("reset_idle");

		// Requests, foreign responses and invalid slots pass straight through
		repeat (40) send_random_packet(1'b0);
		finish_test("forward");

		// Both ways of set 1 are free and each fill leaves an empty slot
		send_fill(32'h0000_1001, 64'h1111_2222_3333_4444);
		send_fill(32'h0000_2001, 64'h5555_6666_7777_8888);
		finish_test("free_way_fill");

		// Third fill to set 1 pushes out line 0x1001 with its data
		send_fill(32'h0000_3001, 64'h9999_aaaa_bbbb_cccc);
		finish_test("eviction");

		// Back to back fills into set 3 come first and a random mix with frequent fills follows
		for (int i = 0; i < 6; i++)
			send_fill({30'(random_bits(30)), 2'd3}, random_bits(64));
		for (int i = 0; i < 300; i++)
		begin
			choose = 2'(random_bits(2));
			if (choose < 2'd2)
				send_fill(32'(random_bits(32)), random_bits(64));
			else
				send_random_packet(1'b1);
		end
		finish_test("mixed");

		// Assertion failures in the bound checker count as errors too
		error_count += u_ring_node.u_ring_node_chk.reset_failures
			+ u_ring_node.u_ring_node_chk.fill_failures
			+ u_ring_node.u_ring_node_chk.writeback_failures;
		$display("Total: %0d packets checked, %0d errors", checks_done, error_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- verilog.f
verilog/ring_pkg.sv
verilog/l1_data_array.sv
verilog/ring_tag_stage.sv
verilog/ring_read_stage.sv
verilog/ring_update_stage.sv
verilog/ring_node.sv
bench/ring_node_chk.sv
bench/ring_node_tb.sv

//--- Makefile
# Verilator build and run for the ring node testbench

VERILATOR ?= verilator
TOP ?= ring_node_tb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, and a run that never reports one also fails
run: compile
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
